// ==== src/sentinel_isa_pkg.sv ====
/*
 * Instruction encodings watched on the tile writeback streams.
 * Both sentinels are addi x0 forms, so they retire as no-ops on the tiles.
 */

`default_nettype none

package sentinel_isa_pkg;

  // Width of one retired instruction word
  localparam int unsigned INSTR_W = 32;

  // Marks the beginning of a profiled region
  localparam logic [INSTR_W-1:0] SENTINEL_START = 32'h5AA0_0013;

  // Marks the end of a profiled region
  localparam logic [INSTR_W-1:0] SENTINEL_END = 32'h5FF0_0013;

endpackage

`default_nettype wire

// ==== src/profile_time_pkg.sv ====
/*
 * Cycle timestamp definitions for the sync profiler.
 * Timestamps wrap after 2^TS_W cycles; one iteration must not span a wrap.
 */

`default_nettype none

package profile_time_pkg;

  // Width of the free-running cycle counter
  localparam int unsigned TS_W = 32;

  // Unsigned cycle count
  typedef logic [TS_W-1:0] timestamp_t;

  // Cost of the start/end sentinel pair itself, in cycles
  localparam timestamp_t SENTINEL_OVERHEAD = timestamp_t'(1);

endpackage

`default_nettype wire

// ==== src/sentinel_stream_if.sv ====
/*
 * One tile's start/end record link.
 * Meaning of valid and ready depends on the link, see the users.
 */

`timescale 1ns/1ns
`default_nettype none

interface sentinel_stream_if;

  logic                         valid;
  profile_time_pkg::timestamp_t start_ts;
  profile_time_pkg::timestamp_t end_ts;
  logic                         ready;

  // Side that offers records
  modport producer (
    output valid,
    output start_ts,
    output end_ts,
    input  ready
  );

  // Side that takes records
  modport consumer (
    input  valid,
    input  start_ts,
    input  end_ts,
    output ready
  );

endinterface

`default_nettype wire

// ==== src/sentinel_detector.sv ====
/*
 * Recognizes start/end sentinels on each tile's writeback stream.
 * Pushes are plain strobes with no back-pressure; a push into a full
 * queue is lost and reported on o_overflow one cycle later.
 */

`timescale 1ns/1ns
`default_nettype none

module sentinel_detector #(
  parameter int unsigned N_TILES = 4
) (
  input  logic                                         clk,
  input  logic                                         i_reset,
  input  logic [N_TILES-1:0]                           i_wb_valid,
  input  logic [N_TILES*sentinel_isa_pkg::INSTR_W-1:0] i_wb_instr,
  output logic [N_TILES-1:0]                           o_orphan_end,
  output logic [N_TILES-1:0]                           o_overflow,
  sentinel_stream_if.producer                          o_stream [N_TILES]
);

  localparam int unsigned INSTR_W = sentinel_isa_pkg::INSTR_W;

  // Zero in the first cycle after reset
  profile_time_pkg::timestamp_t cycle_cnt;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  for (genvar k = 0; k < N_TILES; k++) begin : gen_tile
    logic [INSTR_W-1:0]           instr;
    logic                         is_start;
    logic                         is_end;
    logic                         push;
    logic                         start_open;
    profile_time_pkg::timestamp_t start_ts;
    logic                         orphan_q;
    logic                         overflow_q;

    assign instr    = i_wb_instr[k*INSTR_W +: INSTR_W];
    assign is_start = i_wb_valid[k] && (instr == sentinel_isa_pkg::SENTINEL_START);
    assign is_end   = i_wb_valid[k] && (instr == sentinel_isa_pkg::SENTINEL_END);

    // Record goes out in the same cycle the end sentinel retires
    assign push = is_end && start_open;

    assign o_stream[k].valid    = push;
    assign o_stream[k].start_ts = start_ts;
    assign o_stream[k].end_ts   = cycle_cnt;

    always_ff @(posedge clk) begin
      if (i_reset) begin
        start_open <= 1'b0;
        orphan_q   <= 1'b0;
        overflow_q <= 1'b0;
      end else begin
        orphan_q   <= is_end && !start_open;
        overflow_q <= push && !o_stream[k].ready;
        if (is_start) begin
          start_open <= 1'b1;
        end else if (is_end) begin
          start_open <= 1'b0;
        end
      end
    end

    // A repeated start simply moves the timestamp forward
    always_ff @(posedge clk) begin
      if (is_start) begin
        start_ts <= cycle_cnt;
      end
    end

    assign o_orphan_end[k] = orphan_q;
    assign o_overflow[k]   = overflow_q;
  end

endmodule

`default_nettype wire

// ==== src/sentinel_fifo.sv ====
/*
 * Circular record queue for one tile.
 * Push side: valid is a strobe, ready is not-full. Pop side: valid is
 * not-empty with the head record shown, ready is a pop strobe.
 */

`timescale 1ns/1ns
`default_nettype none

module sentinel_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                i_reset,
  sentinel_stream_if.consumer i_push,
  sentinel_stream_if.producer o_pop
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  profile_time_pkg::timestamp_t mem_start [FIFO_DEPTH];
  profile_time_pkg::timestamp_t mem_end   [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign i_push.ready = (count != CNT_W'(FIFO_DEPTH));
  assign o_pop.valid  = (count != '0);

  assign do_push = i_push.valid && i_push.ready;
  assign do_pop  = o_pop.ready && o_pop.valid;

  assign o_pop.start_ts = mem_start[rd_ptr];
  assign o_pop.end_ts   = mem_end[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_start[wr_ptr] <= i_push.start_ts;
      mem_end[wr_ptr]   <= i_push.end_ts;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the occupancy unchanged
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/sync_reporter.sv ====
/*
 * Pops one record from every tile once all queues hold one and reports
 * latest end minus latest start minus the sentinel overhead.
 * o_sync_cycles is only meaningful from the first o_sync_valid on.
 */

`timescale 1ns/1ns
`default_nettype none

module sync_reporter #(
  parameter int unsigned N_TILES = 4
) (
  input  logic                         clk,
  input  logic                         i_reset,
  sentinel_stream_if.consumer          i_stream [N_TILES],
  output logic                         o_sync_valid,
  output profile_time_pkg::timestamp_t o_sync_cycles,
  output profile_time_pkg::timestamp_t o_sync_count
);

  logic [N_TILES-1:0]           head_valid;
  profile_time_pkg::timestamp_t head_start [N_TILES];
  profile_time_pkg::timestamp_t head_end   [N_TILES];
  logic                         pop_all;
  profile_time_pkg::timestamp_t last_start;
  profile_time_pkg::timestamp_t last_end;

  // Gather the head of each tile queue
  for (genvar k = 0; k < N_TILES; k++) begin : gen_head
    assign head_valid[k] = i_stream[k].valid;
    assign head_start[k] = i_stream[k].start_ts;
    assign head_end[k]   = i_stream[k].end_ts;
    assign i_stream[k].ready = pop_all;
  end

  // All tiles finished this iteration
  assign pop_all = &head_valid;

  always_comb begin
    last_start = '0;
    last_end   = '0;
    for (int unsigned k = 0; k < N_TILES; k++) begin
      if (head_start[k] > last_start) begin
        last_start = head_start[k];
      end
      if (head_end[k] > last_end) begin
        last_end = head_end[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_sync_valid <= 1'b0;
      o_sync_count <= '0;
    end else begin
      o_sync_valid <= pop_all;
      if (pop_all) begin
        o_sync_count <= o_sync_count + 1'b1;
      end
    end
  end

  // Result holds until the next report
  always_ff @(posedge clk) begin
    if (pop_all) begin
      o_sync_cycles <= last_end - last_start - profile_time_pkg::SENTINEL_OVERHEAD;
    end
  end

endmodule

`default_nettype wire

// ==== src/sync_profiler.sv ====
/*
 * Sentinel sync-latency profiler for N_TILES writeback streams.
 * Tile k uses bit k of i_wb_valid and slice k of i_wb_instr.
 * No back-pressure to the tiles; full queues drop records.
 */

`timescale 1ns/1ns
`default_nettype none

module sync_profiler #(
  parameter int unsigned N_TILES    = 4,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                                         clk,
  input  logic                                         i_reset,
  input  logic [N_TILES-1:0]                           i_wb_valid,
  input  logic [N_TILES*sentinel_isa_pkg::INSTR_W-1:0] i_wb_instr,
  output logic                                         o_sync_valid,
  output profile_time_pkg::timestamp_t                 o_sync_cycles,
  output profile_time_pkg::timestamp_t                 o_sync_count,
  output logic [N_TILES-1:0]                           o_orphan_end,
  output logic [N_TILES-1:0]                           o_overflow
);

  // Detector to queue, and queue to reporter, one link per tile
  sentinel_stream_if det_to_fifo [N_TILES] ();
  sentinel_stream_if fifo_to_rep [N_TILES] ();

  sentinel_detector #(
    .N_TILES (N_TILES)
  ) sentinel_detector_i (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_wb_valid   (i_wb_valid),
    .i_wb_instr   (i_wb_instr),
    .o_orphan_end (o_orphan_end),
    .o_overflow   (o_overflow),
    .o_stream     (det_to_fifo)
  );

  for (genvar k = 0; k < N_TILES; k++) begin : gen_fifo
    sentinel_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) sentinel_fifo_i (
      .clk     (clk),
      .i_reset (i_reset),
      .i_push  (det_to_fifo[k]),
      .o_pop   (fifo_to_rep[k])
    );
  end

  sync_reporter #(
    .N_TILES (N_TILES)
  ) sync_reporter_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_stream      (fifo_to_rep),
    .o_sync_valid  (o_sync_valid),
    .o_sync_cycles (o_sync_cycles),
    .o_sync_count  (o_sync_count)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
/*
 * Free-running testbench clock, starts low.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD_NS = 100
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== sim/sync_profiler_assert.sv ====
/*
 * Output pulse rules of the sync profiler, bound into its top level.
 * The one-cycle pulse rules assume stimulus never retires two reportable
 * events back to back on the same output.
 */

`timescale 1ns/1ns
`default_nettype none

module sync_profiler_assert #(
  parameter int unsigned N_TILES = 4
) (
  input logic                         clk,
  input logic                         i_reset,
  input logic                         o_sync_valid,
  input profile_time_pkg::timestamp_t o_sync_count,
  input logic [N_TILES-1:0]           o_orphan_end,
  input logic [N_TILES-1:0]           o_overflow
);

  // Number of failed checks
  int unsigned fail_count = 0;

  // Everything quiet in the cycle after a reset edge
  quiet_after_reset: assert property (@(posedge clk)
    i_reset |=> (!o_sync_valid && (o_orphan_end == '0) && (o_overflow == '0)
                 && (o_sync_count == '0)))
    else begin
      $error("outputs active after reset");
      fail_count++;
    end

  sync_valid_pulse: assert property (@(posedge clk) disable iff (i_reset)
    o_sync_valid |=> !o_sync_valid)
    else begin
      $error("o_sync_valid held longer than one cycle");
      fail_count++;
    end

  // Iteration count moves only with a report, and by one
  count_steps: assert property (@(posedge clk) disable iff (i_reset)
    !$past(i_reset) |-> (o_sync_valid ? (o_sync_count == $past(o_sync_count) + 1'b1)
                                      : (o_sync_count == $past(o_sync_count))))
    else begin
      $error("o_sync_count did not follow o_sync_valid");
      fail_count++;
    end

  for (genvar k = 0; k < N_TILES; k++) begin : gen_tile
    orphan_pulse: assert property (@(posedge clk) disable iff (i_reset)
      o_orphan_end[k] |=> !o_orphan_end[k])
      else begin
        $error("o_orphan_end held longer than one cycle");
        fail_count++;
      end

    overflow_pulse: assert property (@(posedge clk) disable iff (i_reset)
      o_overflow[k] |=> !o_overflow[k])
      else begin
        $error("o_overflow held longer than one cycle");
        fail_count++;
      end
  end

endmodule

bind sync_profiler sync_profiler_assert #(
  .N_TILES (N_TILES)
) sync_profiler_assert_i (
  .clk          (clk),
  .i_reset      (i_reset),
  .o_sync_valid (o_sync_valid),
  .o_sync_count (o_sync_count),
  .o_orphan_end (o_orphan_end),
  .o_overflow   (o_overflow)
);

`default_nettype wire

// ==== sim/sync_profiler_tb.sv ====
/*
 * Testbench for the sync profiler with a cycle-level reference model.
 * Inputs change on the falling edge, outputs are checked there too.
 */

`timescale 1ns/1ns
`default_nettype none

module sync_profiler_tb;

  localparam int unsigned N_TILES    = 4;
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned INSTR_W    = sentinel_isa_pkg::INSTR_W;
  localparam int unsigned CLK_PERIOD = 100;
  // Cycle budgets of reset and the six tests
  localparam int unsigned BUDGET_CYCLES = 3 + 25 + 5 + 28 + 19 + 28 + 38;
  localparam int unsigned MARGIN_CYCLES = 60;

  logic                         clk;
  logic                         i_reset;
  logic [N_TILES-1:0]           i_wb_valid;
  logic [N_TILES*INSTR_W-1:0]   i_wb_instr;
  logic                         o_sync_valid;
  profile_time_pkg::timestamp_t o_sync_cycles;
  profile_time_pkg::timestamp_t o_sync_count;
  logic [N_TILES-1:0]           o_orphan_end;
  logic [N_TILES-1:0]           o_overflow;

  // Reference model state
  profile_time_pkg::timestamp_t cyc;
  logic [N_TILES-1:0]           m_open;
  profile_time_pkg::timestamp_t m_start_ts [N_TILES];
  profile_time_pkg::timestamp_t m_qs [N_TILES][FIFO_DEPTH];
  profile_time_pkg::timestamp_t m_qe [N_TILES][FIFO_DEPTH];
  int                           m_rd [N_TILES];
  int                           m_cnt [N_TILES];

  // Expected outputs for the coming cycle
  logic                         exp_valid;
  profile_time_pkg::timestamp_t exp_cycles;
  profile_time_pkg::timestamp_t exp_count;
  logic [N_TILES-1:0]           exp_orphan;
  logic [N_TILES-1:0]           exp_overflow;

  string test_name;
  int    errors;
  int    test_errors;
  int    test_reports;
  int    tests_run;
  int    tests_failed;

  // Schedule: tile k iteration i starts at off + i*per, ends dur later
  int off [N_TILES];
  int dur [N_TILES];
  int per [N_TILES];
  int nit [N_TILES];

  tb_clock #(.PERIOD_NS (CLK_PERIOD)) tb_clock_i (.clk (clk));

  sync_profiler #(
    .N_TILES    (N_TILES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) sync_profiler_i (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_wb_valid    (i_wb_valid),
    .i_wb_instr    (i_wb_instr),
    .o_sync_valid  (o_sync_valid),
    .o_sync_cycles (o_sync_cycles),
    .o_sync_count  (o_sync_count),
    .o_orphan_end  (o_orphan_end),
    .o_overflow    (o_overflow)
  );

  task automatic model_reset();
    cyc          = '0;
    m_open       = '0;
    exp_valid    = 1'b0;
    exp_cycles   = '0;
    exp_count    = '0;
    exp_orphan   = '0;
    exp_overflow = '0;
    for (int k = 0; k < N_TILES; k++) begin
      m_rd[k]  = 0;
      m_cnt[k] = 0;
    end
  endtask

  task automatic check_outputs();
    assert (o_sync_valid === exp_valid) else begin
      $display("Mismatch in %s: o_sync_valid expected %0b, actual %0b",
               test_name, exp_valid, o_sync_valid);
      test_errors++;
    end
    if (o_sync_valid === 1'b1) begin
      test_reports++;
      assert (!exp_valid || (o_sync_cycles === exp_cycles)) else begin
        $display("Mismatch in %s: o_sync_cycles expected %0d, actual %0d",
                 test_name, exp_cycles, o_sync_cycles);
        test_errors++;
      end
    end
    assert (o_sync_count === exp_count) else begin
      $display("Mismatch in %s: o_sync_count expected %0d, actual %0d",
               test_name, exp_count, o_sync_count);
      test_errors++;
    end
    assert (o_orphan_end === exp_orphan) else begin
      $display("Mismatch in %s: o_orphan_end expected %b, actual %b",
               test_name, exp_orphan, o_orphan_end);
      test_errors++;
    end
    assert (o_overflow === exp_overflow) else begin
      $display("Mismatch in %s: o_overflow expected %b, actual %b",
               test_name, exp_overflow, o_overflow);
      test_errors++;
    end
  endtask

  // One clock cycle: check, drive, then advance the model by one edge
  task automatic drive_cycle(input logic [N_TILES-1:0] v,
                             input logic [N_TILES*INSTR_W-1:0] instr);
    logic                         pop_now;
    logic [N_TILES-1:0]           full;
    profile_time_pkg::timestamp_t max_s;
    profile_time_pkg::timestamp_t max_e;
    logic [INSTR_W-1:0]           w;
    int                           wr;
    @(negedge clk);
    check_outputs();
    i_reset    = 1'b0;
    i_wb_valid = v;
    i_wb_instr = instr;
    pop_now = 1'b1;
    for (int k = 0; k < N_TILES; k++) begin
      full[k] = (m_cnt[k] == FIFO_DEPTH);
      if (m_cnt[k] == 0) begin
        pop_now = 1'b0;
      end
    end
    exp_valid = pop_now;
    if (pop_now) begin
      max_s = '0;
      max_e = '0;
      for (int k = 0; k < N_TILES; k++) begin
        if (m_qs[k][m_rd[k]] > max_s) begin
          max_s = m_qs[k][m_rd[k]];
        end
        if (m_qe[k][m_rd[k]] > max_e) begin
          max_e = m_qe[k][m_rd[k]];
        end
        m_rd[k]  = (m_rd[k] + 1) % FIFO_DEPTH;
        m_cnt[k] = m_cnt[k] - 1;
      end
      exp_cycles = max_e - max_s - profile_time_pkg::SENTINEL_OVERHEAD;
      exp_count  = exp_count + 1;
    end
    exp_orphan   = '0;
    exp_overflow = '0;
    for (int k = 0; k < N_TILES; k++) begin
      w = instr[k*INSTR_W +: INSTR_W];
      if (v[k] && (w == sentinel_isa_pkg::SENTINEL_END)) begin
        exp_orphan[k] = !m_open[k];
        if (m_open[k]) begin
          if (full[k]) begin
            exp_overflow[k] = 1'b1;
          end else begin
            wr = (m_rd[k] + m_cnt[k]) % FIFO_DEPTH;
            m_qs[k][wr] = m_start_ts[k];
            m_qe[k][wr] = cyc;
            m_cnt[k] = m_cnt[k] + 1;
          end
        end
        m_open[k] = 1'b0;
      end else if (v[k] && (w == sentinel_isa_pkg::SENTINEL_START)) begin
        m_open[k]     = 1'b1;
        m_start_ts[k] = cyc;
      end
    end
    cyc = cyc + 1;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle('0, '0);
  endtask

  // Reset covers three rising edges, the next drive_cycle releases it
  task automatic apply_reset();
    i_reset    = 1'b1;
    i_wb_valid = '0;
    i_wb_instr = '0;
    repeat (2) @(negedge clk);
    model_reset();
  endtask

  task automatic run_schedule(input int length);
    logic [N_TILES-1:0]         v;
    logic [N_TILES*INSTR_W-1:0] instr;
    int                         s;
    for (int t = 0; t < length; t++) begin
      v     = '0;
      instr = '0;
      for (int k = 0; k < N_TILES; k++) begin
        for (int i = 0; i < nit[k]; i++) begin
          s = off[k] + i * per[k];
          if (t == s) begin
            v[k] = 1'b1;
            instr[k*INSTR_W +: INSTR_W] = sentinel_isa_pkg::SENTINEL_START;
          end else if (t == s + dur[k]) begin
            v[k] = 1'b1;
            instr[k*INSTR_W +: INSTR_W] = sentinel_isa_pkg::SENTINEL_END;
          end
        end
      end
      drive_cycle(v, instr);
    end
  endtask

  task automatic random_pairs();
    for (int k = 0; k < N_TILES; k++) begin
      off[k] = $urandom % 8;
      dur[k] = 1 + $urandom % 12;
      per[k] = dur[k] + 1;
      nit[k] = 1;
    end
    run_schedule(21);
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    test_errors  = 0;
    test_reports = 0;
  endtask

  task automatic end_test(input int expected_reports);
    assert (test_reports == expected_reports) else begin
      $display("Mismatch in %s: report count expected %0d, actual %0d",
               test_name, expected_reports, test_reports);
      test_errors++;
    end
    tests_run++;
    errors = errors + test_errors;
    if (test_errors > 0) begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d reports, %0d errors", test_name,
             (test_errors == 0) ? "passed" : "failed", test_reports, test_errors);
  endtask

  initial begin
    #((BUDGET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired: run did not finish within %0d cycles",
             BUDGET_CYCLES + MARGIN_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    logic [N_TILES*INSTR_W-1:0] instr;
    int                         assert_fails;
    i_reset      = 1'b1;
    i_wb_valid   = '0;
    i_wb_instr   = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    void'($urandom(32'h348ab17a));
    apply_reset();

    begin_test("global_sync");
    random_pairs();
    idle(4);
    end_test(1);

    begin_test("filtering");
    drive_cycle(4'b0000, {sentinel_isa_pkg::SENTINEL_END, sentinel_isa_pkg::SENTINEL_START,
                          sentinel_isa_pkg::SENTINEL_END, sentinel_isa_pkg::SENTINEL_START});
    drive_cycle(4'b1111, {32'h0000_0013, sentinel_isa_pkg::SENTINEL_START ^ 32'h1,
                          sentinel_isa_pkg::SENTINEL_END ^ 32'h100, 32'h0});
    idle(3);
    end_test(0);

    begin_test("orphan_end");
    instr = '0;
    instr[2*INSTR_W +: INSTR_W] = sentinel_isa_pkg::SENTINEL_END;
    drive_cycle(4'b0100, instr);
    idle(2);
    random_pairs();
    idle(4);
    end_test(1);

    begin_test("buffering");
    for (int k = 0; k < N_TILES; k++) begin
      off[k] = 0;
      per[k] = k + 2;
      dur[k] = k + 1;
      nit[k] = 3;
    end
    run_schedule(15);
    idle(4);
    end_test(3);

    begin_test("overflow");
    // Tile 0 alone overfills its queue
    for (int k = 0; k < N_TILES; k++) begin
      off[k] = 0;
      per[k] = 2;
      dur[k] = 1;
      nit[k] = (k == 0) ? FIFO_DEPTH + 1 : 0;
    end
    run_schedule(2 * (FIFO_DEPTH + 1));
    idle(2);
    for (int k = 0; k < N_TILES; k++) begin
      per[k] = 3;
      dur[k] = 2;
      nit[k] = (k == 0) ? 0 : FIFO_DEPTH;
    end
    run_schedule(3 * FIFO_DEPTH);
    idle(4);
    end_test(FIFO_DEPTH);

    begin_test("reset");
    instr = '0;
    instr[0 +: INSTR_W]       = sentinel_isa_pkg::SENTINEL_START;
    instr[INSTR_W +: INSTR_W] = sentinel_isa_pkg::SENTINEL_START;
    drive_cycle(4'b0011, instr);
    instr[INSTR_W +: INSTR_W] = sentinel_isa_pkg::SENTINEL_END;
    drive_cycle(4'b0010, instr);
    idle(2);
    apply_reset();
    idle(4);
    // Tile 0 start and tile 1 record from before the reset must be gone
    instr[0 +: INSTR_W] = sentinel_isa_pkg::SENTINEL_END;
    drive_cycle(4'b0001, instr);
    idle(2);
    random_pairs();
    idle(4);
    end_test(1);

    assert_fails = sync_profiler_i.sync_profiler_assert_i.fail_count;
    if (assert_fails != 0) begin
      $display("Bound assertions failed %0d times", assert_fails);
      errors = errors + assert_fails;
    end
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if ((errors == 0) && (tests_failed == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sync_profiler.f ====
src/sentinel_isa_pkg.sv
src/profile_time_pkg.sv
src/sentinel_stream_if.sv
src/sentinel_detector.sv
src/sentinel_fifo.sv
src/sync_reporter.sv
src/sync_profiler.sv
sim/tb_clock.sv
sim/sync_profiler_assert.sv
sim/sync_profiler_tb.sv
